/* design/csr_params.svh */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Data and PC width
`define CSR_XLEN 32

// CSR address field of the instruction
`define CSR_ADDR_W 12

// Full width of mcycle/mcycleh
`define CSR_CYCLE_W 64

// MXL=1 (RV32), extensions I and U
`define CSR_MISA_VALUE 32'h4010_0100

`endif

/* design/csr_pkg.sv */
`include "csr_params.svh"

package csr_pkg;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_mode_e;

    typedef enum logic [2:0] {
        CMD_NONE   = 3'd0,
        CMD_RW     = 3'd1,
        CMD_RS     = 3'd2,
        CMD_RC     = 3'd3,
        CMD_ECALL  = 3'd4,
        CMD_EBREAK = 3'd5,
        CMD_MRET   = 3'd6
    } csr_cmd_e;

    // Machine CSRs kept by this stage
    typedef enum logic [`CSR_ADDR_W-1:0] {
        ADDR_MSTATUS  = 12'h300,
        ADDR_MISA     = 12'h301,
        ADDR_MIE      = 12'h304,
        ADDR_MTVEC    = 12'h305,
        ADDR_MSCRATCH = 12'h340,
        ADDR_MEPC     = 12'h341,
        ADDR_MCAUSE   = 12'h342,
        ADDR_MIP      = 12'h344,
        ADDR_MCYCLE   = 12'hB00,
        ADDR_MCYCLEH  = 12'hB80,
        ADDR_CYCLE    = 12'hC00
    } csr_addr_e;

    // Interrupt causes carry the top bit
    typedef enum logic [`CSR_XLEN-1:0] {
        CAUSE_ILLEGAL_INSTRUCTION = 32'd2,
        CAUSE_BREAKPOINT          = 32'd3,
        CAUSE_ECALL_U             = 32'd8,
        CAUSE_ECALL_M             = 32'd11,
        CAUSE_MSI                 = 32'h8000_0003,
        CAUSE_MTI                 = 32'h8000_0007,
        CAUSE_MEI                 = 32'h8000_000B
    } cause_e;

endpackage

/* design/csr_if.sv */
`include "csr_params.svh"

interface csr_if;

    // Decisions from the trap controller
    logic                   csr_we;
    logic                   trap_take;
    csr_pkg::cause_e        trap_cause;
    logic [`CSR_XLEN-1:0]   trap_epc;
    logic                   mret_take;

    // Register state back from the register file
    csr_pkg::priv_mode_e    mode;
    logic                   mstatus_mie;
    logic [`CSR_XLEN-1:0]   mtvec;
    logic [`CSR_XLEN-1:0]   mepc;

    modport regs (
        input  csr_we, trap_take, trap_cause, trap_epc, mret_take,
        output mode, mstatus_mie, mtvec, mepc
    );

    modport ctrl (
        output csr_we, trap_take, trap_cause, trap_epc, mret_take,
        input  mode, mstatus_mie, mtvec, mepc
    );

endinterface

/* design/csr_regfile.sv */
`include "csr_params.svh"

module csr_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid,
    input  csr_pkg::csr_cmd_e       cmd,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  logic [`CSR_XLEN-1:0]    operand,
    input  logic                    ext_irq,
    input  logic                    soft_irq,
    input  logic                    timer_irq,
    output logic [`CSR_XLEN-1:0]    rdata_comb,
    output logic [2:0]              mip_bits,
    output logic [2:0]              mie_bits,
    csr_if.regs                     bus
);

    csr_pkg::priv_mode_e        mode_q;
    csr_pkg::priv_mode_e        mpp_q;
    logic                       mstatus_mie_q;
    logic                       mstatus_mpie_q;
    logic [2:0]                 mie_q;
    logic [2:0]                 mip_q;
    logic [`CSR_XLEN-1:0]       mtvec_q;
    logic [`CSR_XLEN-1:0]       mscratch_q;
    logic [`CSR_XLEN-1:0]       mepc_q;
    logic [`CSR_XLEN-1:0]       mcause_q;
    logic [`CSR_CYCLE_W-1:0]    cycle_q;
    logic [`CSR_CYCLE_W-1:0]    cycle_next;
    logic [`CSR_XLEN-1:0]       mstatus_word;
    logic [`CSR_XLEN-1:0]       wdata;

    // Bit order {MEI, MSI, MTI} placed at 11, 3 and 7
    function automatic logic [`CSR_XLEN-1:0] irq_word(input logic [2:0] b);
        return {20'b0, b[2], 3'b0, b[0], 3'b0, b[1], 3'b0};
    endfunction

    assign mstatus_word = {19'b0, mpp_q, 3'b0, mstatus_mpie_q, 3'b0, mstatus_mie_q, 3'b0};
    assign cycle_next   = cycle_q + 1'b1;

    // Read value before any update of this edge
    always_comb begin
        case (csr_addr)
            csr_pkg::ADDR_MSTATUS:  rdata_comb = mstatus_word;
            csr_pkg::ADDR_MISA:     rdata_comb = `CSR_MISA_VALUE;
            csr_pkg::ADDR_MIE:      rdata_comb = irq_word(mie_q);
            csr_pkg::ADDR_MTVEC:    rdata_comb = mtvec_q;
            csr_pkg::ADDR_MSCRATCH: rdata_comb = mscratch_q;
            csr_pkg::ADDR_MEPC:     rdata_comb = mepc_q;
            csr_pkg::ADDR_MCAUSE:   rdata_comb = mcause_q;
            csr_pkg::ADDR_MIP:      rdata_comb = irq_word(mip_q);
            csr_pkg::ADDR_MCYCLE,
            csr_pkg::ADDR_CYCLE:    rdata_comb = cycle_q[`CSR_XLEN-1:0];
            csr_pkg::ADDR_MCYCLEH:  rdata_comb = cycle_q[`CSR_CYCLE_W-1:`CSR_XLEN];
            default:                rdata_comb = '0;
        endcase
    end

    always_comb begin
        case (cmd)
            csr_pkg::CMD_RW: wdata = operand;
            csr_pkg::CMD_RS: wdata = rdata_comb | operand;
            csr_pkg::CMD_RC: wdata = rdata_comb & ~operand;
            default:         wdata = rdata_comb;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q         <= csr_pkg::PRIV_M;
            mpp_q          <= csr_pkg::PRIV_U;
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_q          <= '0;
            mip_q          <= '0;
            mtvec_q        <= '0;
            mscratch_q     <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
            cycle_q        <= '0;
        end else begin
            // Pins land in mip on every edge
            mip_q   <= {ext_irq, soft_irq, timer_irq};
            cycle_q <= cycle_next;
            if (valid && bus.trap_take) begin
                mepc_q         <= bus.trap_epc;
                mcause_q       <= bus.trap_cause;
                mstatus_mpie_q <= mstatus_mie_q;
                mstatus_mie_q  <= 1'b0;
                mpp_q          <= mode_q;
                mode_q         <= csr_pkg::PRIV_M;
            end else if (valid && bus.mret_take) begin
                mode_q         <= mpp_q;
                mstatus_mie_q  <= mstatus_mpie_q;
                mstatus_mpie_q <= 1'b1;
                mpp_q          <= csr_pkg::PRIV_U;
            end else if (valid && bus.csr_we) begin
                case (csr_addr)
                    csr_pkg::ADDR_MSTATUS: begin
                        mstatus_mie_q  <= wdata[3];
                        mstatus_mpie_q <= wdata[7];
                        // Only U and M exist, anything but 3 maps to U
                        mpp_q <= (wdata[12:11] == 2'b11) ? csr_pkg::PRIV_M : csr_pkg::PRIV_U;
                    end
                    csr_pkg::ADDR_MIE:      mie_q      <= {wdata[11], wdata[3], wdata[7]};
                    csr_pkg::ADDR_MTVEC:    mtvec_q    <= wdata;
                    csr_pkg::ADDR_MSCRATCH: mscratch_q <= wdata;
                    csr_pkg::ADDR_MEPC:     mepc_q     <= {wdata[`CSR_XLEN-1:2], 2'b00};
                    csr_pkg::ADDR_MCAUSE:   mcause_q   <= wdata;
                    csr_pkg::ADDR_MCYCLE:
                        cycle_q <= {cycle_next[`CSR_CYCLE_W-1:`CSR_XLEN], wdata};
                    csr_pkg::ADDR_MCYCLEH:
                        cycle_q <= {wdata, cycle_next[`CSR_XLEN-1:0]};
                    default: begin
                    end
                endcase
            end
        end
    end

    assign mip_bits        = mip_q;
    assign mie_bits        = mie_q;
    assign bus.mode        = mode_q;
    assign bus.mstatus_mie = mstatus_mie_q;
    assign bus.mtvec       = mtvec_q;
    assign bus.mepc        = mepc_q;

endmodule

/* design/irq_select.sv */
module irq_select (
    input  logic                    [2:0] mip_bits,
    input  logic                    [2:0] mie_bits,
    input  logic                    mstatus_mie,
    input  csr_pkg::priv_mode_e     mode,
    output logic                    irq_pending,
    output csr_pkg::cause_e         irq_cause
);

    logic       global_en;
    logic [2:0] enabled;

    // U mode always takes machine interrupts
    assign global_en   = (mode == csr_pkg::PRIV_M) ? mstatus_mie : 1'b1;
    assign enabled     = mip_bits & mie_bits & {3{global_en}};
    assign irq_pending = |enabled;

    // External beats software, software beats timer
    always_comb begin
        if (enabled[2]) begin
            irq_cause = csr_pkg::CAUSE_MEI;
        end else if (enabled[1]) begin
            irq_cause = csr_pkg::CAUSE_MSI;
        end else begin
            irq_cause = csr_pkg::CAUSE_MTI;
        end
    end

endmodule

/* design/trap_ctrl.sv */
`include "csr_params.svh"

module trap_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid,
    input  csr_pkg::csr_cmd_e       cmd,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  logic [`CSR_XLEN-1:0]    pc,
    input  logic                    expt_valid,
    input  csr_pkg::cause_e         expt_cause,
    input  logic                    irq_pending,
    input  csr_pkg::cause_e         irq_cause,
    input  logic [`CSR_XLEN-1:0]    rdata_comb,
    output logic                    rsp_valid,
    output logic [`CSR_XLEN-1:0]    rdata,
    output logic                    trap,
    output logic                    xret,
    output logic [`CSR_XLEN-1:0]    target_pc,
    csr_if.ctrl                     bus
);

    logic                   cmd_is_write;
    logic                   addr_illegal;
    logic                   mret_illegal;
    logic                   expt_raise;
    logic                   irq_take;
    csr_pkg::cause_e        expt_code;
    logic [`CSR_XLEN-1:0]   vec_base;
    logic [`CSR_XLEN-1:0]   trap_vector;
    logic [`CSR_XLEN-1:0]   next_target;

    assign cmd_is_write = (cmd == csr_pkg::CMD_RW) || (cmd == csr_pkg::CMD_RS) ||
                          (cmd == csr_pkg::CMD_RC);

    // Read-only space, or privilege field above the current mode
    assign addr_illegal = (&csr_addr[11:10]) || (csr_addr[9:8] > bus.mode);
    assign mret_illegal = (cmd == csr_pkg::CMD_MRET) && (bus.mode == csr_pkg::PRIV_U);

    assign expt_raise = valid && (expt_valid || cmd == csr_pkg::CMD_ECALL ||
                        cmd == csr_pkg::CMD_EBREAK || (cmd_is_write && addr_illegal) ||
                        mret_illegal);

    // Incoming exception beats anything raised here
    always_comb begin
        if (expt_valid) begin
            expt_code = expt_cause;
        end else if (cmd == csr_pkg::CMD_ECALL) begin
            expt_code = (bus.mode == csr_pkg::PRIV_M) ? csr_pkg::CAUSE_ECALL_M
                                                      : csr_pkg::CAUSE_ECALL_U;
        end else if (cmd == csr_pkg::CMD_EBREAK) begin
            expt_code = csr_pkg::CAUSE_BREAKPOINT;
        end else begin
            expt_code = csr_pkg::CAUSE_ILLEGAL_INSTRUCTION;
        end
    end

    assign irq_take       = valid && !expt_raise && irq_pending;
    assign bus.trap_take  = expt_raise || irq_take;
    assign bus.trap_cause = expt_raise ? expt_code : irq_cause;
    assign bus.trap_epc   = pc;
    assign bus.csr_we     = valid && cmd_is_write && !bus.trap_take;
    assign bus.mret_take  = valid && (cmd == csr_pkg::CMD_MRET) && !bus.trap_take;

    // Vectored mode only offsets interrupts, cause bit 31 shifts out
    assign vec_base    = {bus.mtvec[`CSR_XLEN-1:2], 2'b00};
    assign trap_vector = (bus.mtvec[0] && irq_take)
                       ? vec_base + {bus.trap_cause[`CSR_XLEN-3:0], 2'b00}
                       : vec_base;

    always_comb begin
        if (bus.trap_take) begin
            next_target = trap_vector;
        end else if (bus.mret_take) begin
            next_target = bus.mepc;
        end else begin
            next_target = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            trap      <= 1'b0;
            xret      <= 1'b0;
            target_pc <= '0;
        end else begin
            rsp_valid <= valid;
            trap      <= bus.trap_take;
            xret      <= bus.mret_take;
            target_pc <= next_target;
        end
    end

    // Trapped instructions return zero
    always_ff @(posedge clk) begin
        rdata <= bus.trap_take ? '0 : rdata_comb;
    end

endmodule

/* design/csr_stage.sv */
`include "csr_params.svh"

module csr_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid,
    input  csr_pkg::csr_cmd_e       cmd,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  logic [`CSR_XLEN-1:0]    operand,
    input  logic [`CSR_XLEN-1:0]    pc,
    input  logic                    expt_valid,
    input  csr_pkg::cause_e         expt_cause,
    input  logic                    ext_irq,
    input  logic                    soft_irq,
    input  logic                    timer_irq,
    output logic                    rsp_valid,
    output logic [`CSR_XLEN-1:0]    rdata,
    output logic                    trap,
    output logic                    xret,
    output logic [`CSR_XLEN-1:0]    target_pc,
    output csr_pkg::priv_mode_e     priv_mode
);

    csr_if                  csr_bus ();

    logic [`CSR_XLEN-1:0]   rdata_comb;
    logic [2:0]             mip_bits;
    logic [2:0]             mie_bits;
    logic                   irq_pending;
    csr_pkg::cause_e        irq_cause;

    csr_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .cmd        (cmd),
        .csr_addr   (csr_addr),
        .operand    (operand),
        .ext_irq    (ext_irq),
        .soft_irq   (soft_irq),
        .timer_irq  (timer_irq),
        .rdata_comb (rdata_comb),
        .mip_bits   (mip_bits),
        .mie_bits   (mie_bits),
        .bus        (csr_bus.regs)
    );

    irq_select u_irq_select (
        .mip_bits    (mip_bits),
        .mie_bits    (mie_bits),
        .mstatus_mie (csr_bus.mstatus_mie),
        .mode        (csr_bus.mode),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause)
    );

    trap_ctrl u_trap_ctrl (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .cmd         (cmd),
        .csr_addr    (csr_addr),
        .pc          (pc),
        .expt_valid  (expt_valid),
        .expt_cause  (expt_cause),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause),
        .rdata_comb  (rdata_comb),
        .rsp_valid   (rsp_valid),
        .rdata       (rdata),
        .trap        (trap),
        .xret        (xret),
        .target_pc   (target_pc),
        .bus         (csr_bus.ctrl)
    );

    assign priv_mode = csr_bus.mode;

endmodule

/* sim/csr_stage_assertions.sv */
module csr_stage_assertions (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid,
    input  logic                    rsp_valid,
    input  logic                    trap,
    input  logic                    xret,
    input  csr_pkg::priv_mode_e     priv_mode
);

    logic           seen_valid;
    int unsigned    failures;

    // Set by the first instruction after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            seen_valid <= 1'b0;
        end else if (valid) begin
            seen_valid <= 1'b1;
        end
    end

    rsp_after_valid: assert property (@(posedge clk) disable iff (rst) valid |=> rsp_valid)
        else begin
            $error("rsp_valid missing one cycle after valid");
            failures++;
        end

    no_extra_rsp: assert property (@(posedge clk) disable iff (rst) !valid |=> !rsp_valid)
        else begin
            $error("rsp_valid without valid in the previous cycle");
            failures++;
        end

    trap_xret_excl: assert property (@(posedge clk) disable iff (rst) !(trap && xret))
        else begin
            $error("trap and xret high together");
            failures++;
        end

    mode_legal: assert property (@(posedge clk) disable iff (rst)
        (priv_mode == csr_pkg::PRIV_U) || (priv_mode == csr_pkg::PRIV_M))
        else begin
            $error("priv_mode is neither U nor M");
            failures++;
        end

    quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !seen_valid |-> !rsp_valid)
        else begin
            $error("rsp_valid before the first instruction");
            failures++;
        end

endmodule

/* sim/csr_checker.sv */
`include "csr_params.svh"

module csr_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rsp_valid,
    input  logic [`CSR_XLEN-1:0]    rdata,
    input  logic                    trap,
    input  logic                    xret,
    input  logic [`CSR_XLEN-1:0]    target_pc,
    input  csr_pkg::priv_mode_e     priv_mode
);

    typedef struct packed {
        logic [`CSR_XLEN-1:0]   rdata;
        logic                   trap;
        logic                   xret;
        logic [`CSR_XLEN-1:0]   target_pc;
        csr_pkg::priv_mode_e    mode;
    } rsp_t;

    rsp_t   exp_q[$];
    int     mismatch_count;
    int     protocol_count;
    int     checked_count;

    task automatic expect_rsp(input logic [`CSR_XLEN-1:0] rdata_exp, input logic trap_exp,
                              input logic xret_exp, input logic [`CSR_XLEN-1:0] target_exp,
                              input csr_pkg::priv_mode_e mode_exp);
        rsp_t e;
        e.rdata     = rdata_exp;
        e.trap      = trap_exp;
        e.xret      = xret_exp;
        e.target_pc = target_exp;
        e.mode      = mode_exp;
        exp_q.push_back(e);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    // Response sampled half a cycle after its rising edge
    always @(negedge clk) begin : check_rsp
        rsp_t e;
        if (!rst && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Response at time %0t with no instruction outstanding", $time);
                protocol_count++;
            end else begin
                e = exp_q.pop_front();
                compare_field("rdata", rdata, e.rdata);
                compare_field("trap", {31'b0, trap}, {31'b0, e.trap});
                compare_field("xret", {31'b0, xret}, {31'b0, e.xret});
                compare_field("target_pc", target_pc, e.target_pc);
                compare_field("priv_mode", {30'b0, priv_mode}, {30'b0, e.mode});
                checked_count++;
            end
        end
    end

endmodule

/* sim/csr_stage_tb.sv */
`include "csr_params.svh"

module csr_stage_tb;

    localparam csr_pkg::priv_mode_e MODE_M = csr_pkg::PRIV_M;
    localparam csr_pkg::priv_mode_e MODE_U = csr_pkg::PRIV_U;

    // expt of zero means no incoming exception
    typedef struct packed {
        csr_pkg::csr_cmd_e      cmd;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   operand;
        logic [`CSR_XLEN-1:0]   pc;
        logic [`CSR_XLEN-1:0]   expt;
        logic [2:0]             irq;
        logic [`CSR_XLEN-1:0]   rdata;
        logic                   trap;
        logic                   xret;
        logic [`CSR_XLEN-1:0]   target;
        csr_pkg::priv_mode_e    mode;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   valid;
    csr_pkg::csr_cmd_e      cmd;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`CSR_XLEN-1:0]   operand;
    logic [`CSR_XLEN-1:0]   pc;
    logic                   expt_valid;
    csr_pkg::cause_e        expt_cause;
    logic                   ext_irq;
    logic                   soft_irq;
    logic                   timer_irq;
    logic                   rsp_valid;
    logic [`CSR_XLEN-1:0]   rdata;
    logic                   trap;
    logic                   xret;
    logic [`CSR_XLEN-1:0]   target_pc;
    csr_pkg::priv_mode_e    priv_mode;

    row_t   rows[$];
    int     cycles;
    int     cycle_limit;
    int     seed;
    int     errors;

    csr_stage UUT (.*);

    csr_checker u_checker (.*);

    bind csr_stage csr_stage_assertions u_assertions (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: responses still missing after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic add_row(input csr_pkg::csr_cmd_e c, input logic [11:0] a,
                           input logic [31:0] op, input logic [31:0] p, input logic [31:0] ex,
                           input logic [2:0] irq, input logic [31:0] rd, input logic tr,
                           input logic xr, input logic [31:0] tgt,
                           input csr_pkg::priv_mode_e m);
        rows.push_back({c, a, op, p, ex, irq, rd, tr, xr, tgt, m});
    endtask

    task automatic load_table();
        // Read-write, set and clear on mscratch, mtvec and misa
        add_row(csr_pkg::CMD_RW, 12'h340, 'h1234_5678, 'h100, 0, 0, 0, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h340, 'h0000_00F0, 'h104, 0, 0, 'h1234_5678, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RC, 12'h340, 'h1000_0008, 'h108, 0, 0, 'h1234_56F8, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RW, 12'h305, 'h800, 'h10C, 0, 0, 0, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RW, 12'h301, 'hFFFF_FFFF, 'h110, 0, 0, 'h4010_0100, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h301, 0, 'h114, 0, 0, 'h4010_0100, 0, 0, 0, MODE_M);
        // Cycle alias is read-only space
        add_row(csr_pkg::CMD_RW, 12'hC00, 0, 'h200, 0, 0, 0, 1, 0, 'h800, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h341, 0, 'h204, 0, 0, 'h200, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h342, 0, 'h208, 0, 0, 'h2, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h300, 0, 'h20C, 0, 0, 'h1800, 0, 0, 0, MODE_M);
        // MPIE set, MPP to U, then drop to U
        add_row(csr_pkg::CMD_RW, 12'h300, 'h80, 'h210, 0, 0, 'h1800, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RW, 12'h341, 'h303, 'h214, 0, 0, 'h200, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_MRET, 12'h000, 0, 'h218, 0, 0, 0, 0, 1, 'h300, MODE_U);
        add_row(csr_pkg::CMD_RW, 12'h340, 'hDEAD, 'h300, 0, 0, 0, 1, 0, 'h800, MODE_M);
        add_row(csr_pkg::CMD_MRET, 12'h000, 0, 'h304, 0, 0, 0, 0, 1, 'h300, MODE_U);
        add_row(csr_pkg::CMD_ECALL, 12'h000, 0, 'h308, 0, 0, 0, 1, 0, 'h800, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h342, 0, 'h30C, 0, 0, 'h8, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_ECALL, 12'h000, 0, 'h310, 0, 0, 0, 1, 0, 'h800, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h342, 0, 'h314, 0, 0, 'hB, 0, 0, 0, MODE_M);
        // MEIE and MTIE, then global MIE
        add_row(csr_pkg::CMD_RW, 12'h304, 'h880, 'h318, 0, 0, 0, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RW, 12'h300, 'h8, 'h31C, 0, 0, 'h1800, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h340, 'hFFFF, 'h400, csr_pkg::CAUSE_BREAKPOINT,
                3'b100, 0, 1, 0, 'h800, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h342, 0, 'h404, 0, 0, 'h3, 0, 0, 0, MODE_M);
        // Vectored mtvec, external and timer pending together
        add_row(csr_pkg::CMD_RW, 12'h305, 'h801, 'h408, 0, 0, 'h800, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h300, 'h8, 'h40C, 0, 0, 'h1880, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RW, 12'h340, 'h5555, 'h500, 0, 3'b101, 0, 1, 0, 'h82C, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h340, 0, 'h504, 0, 0, 'h0234_56F0, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h342, 0, 'h508, 0, 0, 'h8000_000B, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_MRET, 12'h000, 0, 'h50C, 0, 0, 0, 0, 1, 'h500, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h300, 0, 'h510, 0, 0, 'h88, 0, 0, 0, MODE_M);
        add_row(csr_pkg::CMD_NONE, 12'h000, 0, 'h700, 0, 3'b001, 0, 1, 0, 'h81C, MODE_M);
        // Exceptions ignore vectoring
        add_row(csr_pkg::CMD_EBREAK, 12'h000, 0, 'h710, 0, 0, 0, 1, 0, 'h800, MODE_M);
        add_row(csr_pkg::CMD_RS, 12'h342, 0, 'h714, 0, 0, 'h3, 0, 0, 0, MODE_M);
    endtask

    // One setup cycle lets the pins reach mip before valid
    task automatic apply_row(input row_t r);
        valid      = 1'b0;
        cmd        = r.cmd;
        csr_addr   = r.addr;
        operand    = r.operand;
        pc         = r.pc;
        expt_valid = (r.expt != '0);
        expt_cause = csr_pkg::cause_e'(r.expt);
        {ext_irq, soft_irq, timer_irq} = r.irq;
        @(negedge clk);
        valid = 1'b1;
        u_checker.expect_rsp(r.rdata, r.trap, r.xret, r.target, r.mode);
        @(negedge clk);
        valid = 1'b0;
        repeat ($urandom % 4) @(negedge clk);
    endtask

    initial begin
        rst        = 1'b1;
        valid      = 1'b0;
        cmd        = csr_pkg::CMD_NONE;
        csr_addr   = '0;
        operand    = '0;
        pc         = '0;
        expt_valid = 1'b0;
        expt_cause = csr_pkg::CAUSE_ILLEGAL_INSTRUCTION;
        ext_irq    = 1'b0;
        soft_irq   = 1'b0;
        timer_irq  = 1'b0;
        seed       = 32'hfb10d13a;
        void'($urandom(seed));
        load_table();
        cycle_limit = rows.size() * 6 + 40;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        while (u_checker.checked_count < rows.size()) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        errors = u_checker.mismatch_count + u_checker.protocol_count +
                 UUT.u_assertions.failures;
        $display("Errors: %0d value, %0d protocol, %0d assertion", u_checker.mismatch_count,
                 u_checker.protocol_count, UUT.u_assertions.failures);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+design
design/csr_pkg.sv
design/csr_if.sv
design/csr_regfile.sv
design/irq_select.sv
design/trap_ctrl.sv
design/csr_stage.sv
sim/csr_stage_assertions.sv
sim/csr_checker.sv
sim/csr_stage_tb.sv

/* Bender.yml */
package:
  name: csr_stage

sources:
  - include_dirs:
      - design
    files:
      - design/csr_pkg.sv
      - design/csr_if.sv
      - design/csr_regfile.sv
      - design/irq_select.sv
      - design/trap_ctrl.sv
      - design/csr_stage.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/csr_stage_assertions.sv
      - sim/csr_checker.sv
      - sim/csr_stage_tb.sv
